// ==== vlog.f ====
fetchPkg.sv
ctrlBus.sv
progCounter.sv
instrRom.sv
instrDecoder.sv
hazardUnit.sv
fetchStage.sv
fetchStageTb_assertions.sv
fetchStageTb.sv

// ==== fetchStageTb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage testbench
// Program load, random redirects, directed
// hazard and halt runs, reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetchStageTb import fetchPkg::*; ();

    localparam int romDepth     = 8;     // Whole program loads inside the reset window
    localparam int idxBits      = $clog2(romDepth);
    localparam int resetCycles  = 10;
    localparam int randomCycles = 1500;
    localparam int maxCycles    = 2000;  // Two resets, random run, ~60 directed, margin
    localparam logic [dataWidth-1:0] addrMask = dataWidth'(romDepth * 2 - 2);

    typedef struct packed {
        logic    regWrite;
        regAddrT writeReg;
        logic    memEnable, memWr, branch, jump, regJmp, halt, ctrlErr;
        logic    readsRs, readsRt;
    } ctrlT;

    logic                 clk = 1'b0;
    logic                 rstN, redirect, loadEn;
    logic [dataWidth-1:0] redirectAddr, loadAddr, pc;
    instrT                loadData, instr;
    logic                 issueValid, regWrite, memEnable, memWr, branch, jump;
    logic                 regJmp, halt, ctrlErr, stall;
    regAddrT              writeReg;

    instrT  prog [romDepth];  // Copy of the memory contents
    opcodeT opPool [11] = '{opNop, opJ, opJr, opJal, opAddi, opBeqz, opSt, opLd, opLbi,
                            opAluR, 5'b11110};  // Last entry is no known opcode
    integer seed = 32'he8a1_d033;
    int     cycleCount = 0;

    // Reference model state
    logic [dataWidth-1:0] refPc        = '0;
    logic                 refValid     = 1'b0;
    logic                 refLdPending = 1'b0;
    regAddrT              refLdDest    = '0;
    instrT                expRaw, expIssue;
    ctrlT                 rawCtrl, expCtrl;
    logic                 expStall;

    fetchStage #(.romDepth(romDepth)) dut (.*);

    always #10 clk = ~clk;

    task automatic checkEq(input logic [15:0] actual, input logic [15:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    function automatic ctrlT refDecode(input instrT w);
        ctrlT c;
        c = '0;
        case (w[15:11])
            opAddi:  {c.regWrite, c.readsRs} = 2'b11;
            opLd:    {c.regWrite, c.memEnable, c.readsRs} = 3'b111;
            opSt:    {c.memEnable, c.memWr, c.readsRs, c.readsRt} = 4'b1111;
            opAluR:  {c.regWrite, c.readsRs, c.readsRt} = 3'b111;
            opLbi:   c.regWrite = 1'b1;
            opBeqz:  {c.branch, c.readsRs} = 2'b11;
            opJ:     c.jump = 1'b1;
            opJr:    {c.jump, c.regJmp, c.readsRs} = 3'b111;
            opJal:   {c.regWrite, c.jump} = 2'b11;
            opHalt:  c.halt = 1'b1;
            opNop:   ;
            default: c.ctrlErr = 1'b1;
        endcase
        // Destination by format, zero without a write
        case (w[15:11])
            opAddi, opLd: c.writeReg = w[7:5];
            opAluR:       c.writeReg = w[4:2];
            opLbi:        c.writeReg = w[10:8];
            opJal:        c.writeReg = linkReg;
            default:      c.writeReg = '0;
        endcase
        return c;
    endfunction

    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic pulseRedirect(input logic [dataWidth-1:0] target);
        redirect     = 1'b1;
        redirectAddr = target;
        stepCycle();
        redirect = 1'b0;
    endtask

    task automatic buildRandomProg();
        for (int i = 0; i < romDepth; i++) begin
            prog[i] = {opPool[$unsigned($random(seed)) % 11], 11'($random(seed))};
        end
        prog[romDepth-1] = {opHalt, 11'($random(seed))};  // The only HALT
    endtask

    task automatic buildDirectedProg();
        prog[0] = bubbleInstr;                        // Skipped on the first edge
        prog[1] = {opLd, 3'd2, 3'd1, 5'd0};           // r1 from memory
        prog[2] = {opAddi, 3'd1, 3'd4, 5'd3};         // Needs r1
        prog[3] = {opLd, 3'd0, 3'd3, 5'd0};
        prog[4] = {opAluR, 3'd4, 3'd5, 3'd6, 2'd0};   // Independent of r3
        prog[5] = {5'b10111, 11'h2a5};
        prog[6] = {opJal, 11'h000};
        prog[7] = {opHalt, 11'h000};
    endtask

    // Reset for resetCycles edges, program written meanwhile
    task automatic resetAndLoad();
        rstN     = 1'b0;
        redirect = 1'b0;
        for (int i = 0; i < romDepth; i++) begin
            loadEn   = 1'b1;
            loadAddr = dataWidth'(i * 2);
            loadData = prog[i];
            stepCycle();
        end
        loadEn = 1'b0;
        repeat (resetCycles - romDepth) stepCycle();
        rstN = 1'b1;
    endtask

    always_comb begin
        expRaw   = prog[refPc[idxBits:1]];
        rawCtrl  = refDecode(expRaw);
        expStall = refValid && refLdPending &&
                   ((rawCtrl.readsRs && expRaw[10:8] == refLdDest) ||
                    (rawCtrl.readsRt && expRaw[7:5] == refLdDest));
        expIssue = expStall ? bubbleInstr : expRaw;
        expCtrl  = refValid ? refDecode(expIssue) : '0;
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            refPc        <= '0;
            refValid     <= 1'b0;
            refLdPending <= 1'b0;
        end else begin
            refValid  <= 1'b1;
            refLdDest <= expIssue[7:5];
            if (redirect) begin
                refPc        <= redirectAddr & addrMask;
                refLdPending <= 1'b0;  // Squashed
            end else begin
                refLdPending <= refValid && expIssue[15:11] == opLd;
                if (!expStall && !expCtrl.halt) begin
                    refPc <= (refPc + dataWidth'(2)) & addrMask;
                end
            end
        end
    end

    always @(negedge clk) begin
        checkEq(issueValid, refValid, "issueValid");
        checkEq(pc, refPc, "pc");
        checkEq(stall, expStall, "stall");
        if (refValid) begin
            checkEq(instr, expIssue, "instr");
        end
        checkEq({regWrite, writeReg, memEnable, memWr, branch, jump, regJmp, halt, ctrlErr},
                {expCtrl.regWrite, expCtrl.writeReg, expCtrl.memEnable, expCtrl.memWr,
                 expCtrl.branch, expCtrl.jump, expCtrl.regJmp, expCtrl.halt, expCtrl.ctrlErr},
                "control fields");
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > maxCycles) begin
            $display("Timeout: the run did not end within %0d cycles", maxCycles);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        rstN         = 1'b0;
        redirect     = 1'b0;
        redirectAddr = '0;
        loadEn       = 1'b0;
        loadAddr     = '0;
        loadData     = '0;
        buildRandomProg();
        resetAndLoad();
        repeat (randomCycles) begin
            stepCycle();
            redirect     = ($random(seed) & 15) == 0;  // About 1 in 16
            redirectAddr = dataWidth'($random(seed)) & 16'hfffe;
        end
        rstN = 1'b0;
        buildDirectedProg();
        resetAndLoad();
        while (!halt) stepCycle();
        repeat (4) stepCycle();      // PC must hold under halt
        pulseRedirect(16'h0002);     // LD issues here
        pulseRedirect(16'h0004);     // Squashes it, so no stall at 4
        while (!halt) stepCycle();
        pulseRedirect(16'h0002);
        while (!stall) stepCycle();
        pulseRedirect(16'h0006);     // Redirect beats the stall
        while (!halt) stepCycle();
        pulseRedirect(16'h0010);     // Past the top, wraps to 0
        repeat (6) stepCycle();
        if (dut.assertChk.failCount == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", dut.assertChk.failCount);
            $display("Testbench failed");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

// ==== fetchStageTb_assertions.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bound checks on the fetch stage
// Stall length, halt hold, reset outputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetchStageTb_assertions import fetchPkg::*; (
    input logic                 clk,
    input logic                 rstN,
    input logic                 redirect,
    input logic [dataWidth-1:0] pc,
    input logic                 issueValid,
    input logic                 regWrite,
    input regAddrT              writeReg,
    input logic                 memEnable, memWr, branch, jump, regJmp, halt, ctrlErr,
    input logic                 stall
);

    int failCount = 0;  // Read by the testbench at the end

    // A bubble is never a load, so no second stall
    stallOnce: assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
        else begin
            failCount++;
            $error("stall stayed high for two cycles");
        end

    haltHold: assert property (@(posedge clk) disable iff (!rstN)
        halt && !redirect |=> $stable(pc))
        else begin
            failCount++;
            $error("pc moved under halt without a redirect");
        end

    // Decoders are disabled until the first edge out of reset
    ctrlLow: assert property (@(posedge clk) !issueValid |->
        !(regWrite || memEnable || memWr || branch || jump || regJmp || halt || ctrlErr
          || stall) && writeReg == '0)
        else begin
            failCount++;
            $error("control output high while issueValid is low");
        end

endmodule

bind fetchStage fetchStageTb_assertions assertChk (.*);

// ==== fetchStage.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch stage top level
// PC, memory, two decoders, hazard unit
// and bubble insertion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module fetchStage import fetchPkg::*; #(
    parameter int romDepth = 256
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 redirect,
    input  logic [dataWidth-1:0] redirectAddr,
    input  logic                 loadEn,
    input  logic [dataWidth-1:0] loadAddr,
    input  instrT                loadData,
    output logic                 issueValid,
    output logic [dataWidth-1:0] pc,
    output instrT                instr,
    output logic                 regWrite,
    output regAddrT              writeReg,
    output logic                 memEnable,
    output logic                 memWr,
    output logic                 branch,
    output logic                 jump,
    output logic                 regJmp,
    output logic                 halt,
    output logic                 ctrlErr,
    output logic                 stall
);

    instrT romWord;
    logic  hold;

    ctrlBus chkBus ();
    ctrlBus issueBus ();

    // First valid cycle follows the first edge out of reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= 1'b1;
        end
    end

    progCounter #(.romDepth(romDepth)) pcReg (
        .clk          (clk),
        .rstN         (rstN),
        .redirect     (redirect),
        .redirectAddr (redirectAddr),
        .hold         (hold),
        .pc           (pc)
    );

    instrRom #(.romDepth(romDepth)) rom (
        .clk      (clk),
        .pc       (pc),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdata    (romWord)
    );

    // Raw word, only for the hazard check
    instrDecoder chkDec (
        .instrWord (romWord),
        .enable    (issueValid),
        .ctrl      (chkBus.producer)
    );

    hazardUnit hazard (
        .clk      (clk),
        .rstN     (rstN),
        .redirect (redirect),
        .chk      (chkBus.reader),
        .issued   (issueBus.reader),
        .stall    (stall)
    );

    assign instr = stall ? bubbleInstr : romWord;  // Bubble replaces the dependent word

    instrDecoder issueDec (
        .instrWord (instr),
        .enable    (issueValid),
        .ctrl      (issueBus.producer)
    );

    assign hold = stall | issueBus.halt;

    assign regWrite  = issueBus.regWrite;
    assign writeReg  = issueBus.writeReg;
    assign memEnable = issueBus.memEnable;
    assign memWr     = issueBus.memWr;
    assign branch    = issueBus.branch;
    assign jump      = issueBus.jump;
    assign regJmp    = issueBus.regJmp;
    assign halt      = issueBus.halt;
    assign ctrlErr   = issueBus.ctrlErr;

endmodule

// ==== hazardUnit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load-use hazard detection
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module hazardUnit import fetchPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   redirect,
    ctrlBus.reader chk,
    ctrlBus.reader issued,
    output logic   stall
);

    logic    issuedLoad;
    logic    ldPending;   // Last issued instruction was LD
    regAddrT ldDest;
    logic    rsHit;
    logic    rtHit;

    // A bubble decodes as NOP, so it never counts as a load
    assign issuedLoad = issued.valid & issued.memEnable & ~issued.memWr & issued.regWrite;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ldPending <= 1'b0;
        end else if (redirect) begin
            ldPending <= 1'b0;   // Squashed path
        end else begin
            ldPending <= issuedLoad;
        end
    end

    always_ff @(posedge clk) begin
        ldDest <= issued.writeReg;
    end

    assign rsHit = chk.readsRs && (chk.rsAddr == ldDest);
    assign rtHit = chk.readsRt && (chk.rtAddr == ldDest);

    assign stall = chk.valid & ldPending & (rsHit | rtHit);

endmodule

// ==== instrDecoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction decoder
// Control fields, destination and sources
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instrDecoder import fetchPkg::*; (
    input  instrT    instrWord,
    input  logic     enable,
    ctrlBus.producer ctrl
);

    // Where the destination register comes from
    typedef enum logic [1:0] {
        dstRs,
        dstRt,
        dstRd,
        dstLink
    } dstSelT;

    opcodeT  opcode;
    dstSelT  dstSel;
    regAddrT dstReg;
    logic    regWriteD;
    logic    memEnableD;
    logic    memWrD;
    logic    branchD;
    logic    jumpD;
    logic    regJmpD;
    logic    haltD;
    logic    errD;
    logic    readsRsD;
    logic    readsRtD;

    assign opcode = instrWord[opHi:opLo];

    always_comb begin
        regWriteD  = 1'b0;
        memEnableD = 1'b0;
        memWrD     = 1'b0;
        branchD    = 1'b0;
        jumpD      = 1'b0;
        regJmpD    = 1'b0;
        haltD      = 1'b0;
        errD       = 1'b0;
        readsRsD   = 1'b0;
        readsRtD   = 1'b0;
        dstSel     = dstRs;
        case (opcode)
            opAddi: begin
                regWriteD = 1'b1;
                dstSel    = dstRt;
                readsRsD  = 1'b1;
            end
            opLd: begin
                regWriteD  = 1'b1;
                dstSel     = dstRt;
                memEnableD = 1'b1;
                readsRsD   = 1'b1;
            end
            opSt: begin
                memEnableD = 1'b1;
                memWrD     = 1'b1;
                readsRsD   = 1'b1;
                readsRtD   = 1'b1;   // Store data
            end
            opAluR: begin
                regWriteD = 1'b1;
                dstSel    = dstRd;
                readsRsD  = 1'b1;
                readsRtD  = 1'b1;
            end
            opLbi: begin
                regWriteD = 1'b1;
                dstSel    = dstRs;  // Writes rs, reads nothing
            end
            opBeqz: begin
                branchD  = 1'b1;
                readsRsD = 1'b1;
            end
            opJ: jumpD = 1'b1;
            opJr: begin
                jumpD    = 1'b1;
                regJmpD  = 1'b1;
                readsRsD = 1'b1;
            end
            opJal: begin
                regWriteD = 1'b1;
                jumpD     = 1'b1;
                dstSel    = dstLink;
            end
            opHalt: haltD = 1'b1;
            opNop: ;
            default: errD = 1'b1;
        endcase
    end

    always_comb begin
        case (dstSel)
            dstRt:   dstReg = instrWord[rtHi:rtLo];
            dstRd:   dstReg = instrWord[rdHi:rdLo];
            dstLink: dstReg = linkReg;
            default: dstReg = instrWord[rsHi:rsLo];
        endcase
    end

    // Everything low while disabled
    assign ctrl.valid     = enable;
    assign ctrl.regWrite  = enable & regWriteD;
    assign ctrl.writeReg  = (enable && regWriteD) ? dstReg : '0;
    assign ctrl.memEnable = enable & memEnableD;
    assign ctrl.memWr     = enable & memWrD;
    assign ctrl.branch    = enable & branchD;
    assign ctrl.jump      = enable & jumpD;
    assign ctrl.regJmp    = enable & regJmpD;
    assign ctrl.halt      = enable & haltD;
    assign ctrl.ctrlErr   = enable & errD;
    assign ctrl.readsRs   = enable & readsRsD;
    assign ctrl.readsRt   = enable & readsRtD;
    assign ctrl.rsAddr    = enable ? instrWord[rsHi:rsLo] : '0;
    assign ctrl.rtAddr    = enable ? instrWord[rtHi:rtLo] : '0;

endmodule

// ==== instrRom.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Instruction memory
// Async read, sync load port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module instrRom import fetchPkg::*; #(
    parameter int romDepth = 256
) (
    input  logic                 clk,
    input  logic [dataWidth-1:0] pc,
    input  logic                 loadEn,
    input  logic [dataWidth-1:0] loadAddr,
    input  instrT                loadData,
    output instrT                rdata
);

    localparam int idxBits = $clog2(romDepth);

    instrT mem [romDepth];

    logic [idxBits-1:0] rdIdx;
    logic [idxBits-1:0] wrIdx;

    // Byte addresses, so drop bit 0
    assign rdIdx = pc[idxBits:1];
    assign wrIdx = loadAddr[idxBits:1];

    assign rdata = mem[rdIdx];

    // Program load, only driven while the core sits in reset
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[wrIdx] <= loadData;
        end
    end

endmodule

// ==== progCounter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Program counter register
// Redirect, hold and increment by two
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module progCounter import fetchPkg::*; #(
    parameter int romDepth = 256
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 redirect,
    input  logic [dataWidth-1:0] redirectAddr,
    input  logic                 hold,
    output logic [dataWidth-1:0] pc
);

    // Byte span of the memory with bit 0 cleared
    localparam logic [dataWidth-1:0] addrMask = dataWidth'((romDepth * 2 - 1) & ~1);

    logic [dataWidth-1:0] pcInc;
    logic [dataWidth-1:0] pcNext;

    assign pcInc = (pc + dataWidth'(2)) & addrMask;  // Wraps at the top of memory

    // Redirect beats stall and halt
    always_comb begin
        if (redirect) begin
            pcNext = redirectAddr & addrMask;
        end else if (hold) begin
            pcNext = pc;
        end else begin
            pcNext = pcInc;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// ==== ctrlBus.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded control fields of one instruction
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface ctrlBus import fetchPkg::*; ();

    logic    valid;      // Decoder enabled
    logic    regWrite;
    regAddrT writeReg;   // Zero when no write
    logic    memEnable;
    logic    memWr;
    logic    branch;
    logic    jump;
    logic    regJmp;
    logic    halt;
    logic    ctrlErr;    // Unknown opcode
    logic    readsRs;
    logic    readsRt;
    regAddrT rsAddr;
    regAddrT rtAddr;

    modport producer (
        output valid, regWrite, writeReg, memEnable, memWr, branch, jump,
               regJmp, halt, ctrlErr, readsRs, readsRt, rsAddr, rtAddr
    );

    modport reader (
        input valid, regWrite, writeReg, memEnable, memWr, branch, jump,
              regJmp, halt, ctrlErr, readsRs, readsRt, rsAddr, rtAddr
    );

endinterface

// ==== fetchPkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions of the fetch stage
// Widths, word types, opcode constants,
// bubble word and register field slices
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fetchPkg;

    // Instruction and PC width
    localparam int dataWidth = 16;

    typedef logic [dataWidth-1:0] instrT;
    typedef logic [2:0]           regAddrT;
    typedef logic [4:0]           opcodeT;

    // Opcode field
    localparam int opHi = 15;
    localparam int opLo = 11;

    // Source register, always at the same spot
    localparam int rsHi = 10;
    localparam int rsLo = 8;

    // Second source, also the I-type destination
    localparam int rtHi = 7;
    localparam int rtLo = 5;

    // R-type destination
    localparam int rdHi = 4;
    localparam int rdLo = 2;

    // Control transfer
    localparam opcodeT opHalt  = 5'b00000;
    localparam opcodeT opNop   = 5'b00001;
    localparam opcodeT opJ     = 5'b00100;
    localparam opcodeT opJr    = 5'b00101;  // Jump to rs
    localparam opcodeT opJal   = 5'b00110;  // Writes the link register

    // Immediate arithmetic and branches
    localparam opcodeT opAddi  = 5'b01000;
    localparam opcodeT opBeqz  = 5'b01100;

    // Memory access
    localparam opcodeT opSt    = 5'b10000;
    localparam opcodeT opLd    = 5'b10001;

    // Load byte immediate and register ALU ops
    localparam opcodeT opLbi   = 5'b11000;
    localparam opcodeT opAluR  = 5'b11011;

    // NOP word with zero register fields, issued on a stall
    localparam instrT bubbleInstr = 16'h0800;

    // JAL return address goes here
    localparam regAddrT linkReg = 3'd7;

endpackage
